/* Makefile */
# Verilator build and run of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_conv2d
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* hw/conv2d_systolic_top.sv */
`default_nettype none

module conv2d_systolic_top (
	input  wire               clk_in,
	input  wire               arst_n,
	input  wire               start,
	input  conv_pkg::pixel_t  image [conv_pkg::IMG_DIM * conv_pkg::IMG_DIM],
	input  conv_pkg::pixel_t  filter [conv_pkg::N_TAPS],
	output conv_pkg::acc_t    result [conv_pkg::N_WIN],
	output logic              done
);

	// ----------------------------------------------------------------------
	// Internal nets
	// ----------------------------------------------------------------------

	logic issue;
	conv_pkg::win_idx_t issue_win;

	logic sum_valid;
	conv_pkg::win_idx_t sum_win;
	conv_pkg::acc_t sum;

	// Skewed operands into the chain
	tap_if taps ();

	// ----------------------------------------------------------------------
	// Blocks
	// ----------------------------------------------------------------------

	window_sequencer u_seq (
		.clk_in    (clk_in),
		.arst_n    (arst_n),
		.start     (start),
		.issue     (issue),
		.issue_win (issue_win)
	);

	operand_skew u_skew (
		.clk_in    (clk_in),
		.arst_n    (arst_n),
		.issue     (issue),
		.issue_win (issue_win),
		.image     (image),
		.taps      (taps.src)
	);

	mac_chain u_chain (
		.clk_in    (clk_in),
		.arst_n    (arst_n),
		.filter    (filter),
		.taps      (taps.snk),
		.sum_valid (sum_valid),
		.sum_win   (sum_win),
		.sum       (sum)
	);

	result_collector u_collect (
		.clk_in    (clk_in),
		.arst_n    (arst_n),
		.sum_valid (sum_valid),
		.sum_win   (sum_win),
		.sum       (sum),
		.result    (result),
		.done      (done)
	);

endmodule

`default_nettype wire

/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// ----------------------------------------------------------------------
	// Geometry
	// ----------------------------------------------------------------------

	// Image side and filter side
	localparam int IMG_DIM = 4;
	localparam int K_DIM   = 3;

	// Valid convolution leaves a 2x2 output
	localparam int OUT_DIM = IMG_DIM - K_DIM + 1;

	// One MAC stage per filter tap, tap s at row s/3, column s%3
	localparam int N_TAPS = K_DIM * K_DIM;

	// Window w at output row w/2, column w%2
	localparam int N_WIN = OUT_DIM * OUT_DIM;

	// Start edge to done edge: skew register, chain, window spacing, capture
	localparam int RUN_LATENCY = 1 + N_TAPS + (N_WIN - 1) + 1;

	// ----------------------------------------------------------------------
	// Types
	// ----------------------------------------------------------------------

	typedef logic [7:0] pixel_t;
	// Wraps modulo 256
	typedef logic [7:0] acc_t;
	typedef logic [1:0] win_idx_t;

endpackage

`default_nettype wire

/* hw/mac_chain.sv */
`default_nettype none

module mac_chain (
	input  wire                 clk_in,
	input  wire                 arst_n,
	input  conv_pkg::pixel_t    filter [conv_pkg::N_TAPS],
	tap_if.snk                  taps,
	output logic                sum_valid,
	output conv_pkg::win_idx_t  sum_win,
	output conv_pkg::acc_t      sum
);

	localparam int LAST = conv_pkg::N_TAPS - 1;

	// Per-stage pipeline registers
	logic               vld_q [conv_pkg::N_TAPS];
	conv_pkg::win_idx_t win_q [conv_pkg::N_TAPS];
	conv_pkg::acc_t     acc_q [conv_pkg::N_TAPS];

	genvar s;
	generate
		for (s = 0; s < conv_pkg::N_TAPS; s++) begin : g_stage
			logic               vld_in;
			conv_pkg::win_idx_t win_in;
			conv_pkg::acc_t     acc_in;
			conv_pkg::acc_t     prod;

			// Stage 0 starts each window from zero
			if (s == 0) begin : g_head
				assign vld_in = taps.valid;
				assign win_in = taps.win;
				assign acc_in = '0;
			end else begin : g_body
				assign vld_in = vld_q[s-1];
				assign win_in = win_q[s-1];
				assign acc_in = acc_q[s-1];
			end

			// Only the low byte survives the wrap
			assign prod = conv_pkg::acc_t'(filter[s] * taps.pix[s]);

			always_ff @(posedge clk_in or negedge arst_n) begin
				if (!arst_n) begin
					vld_q[s] <= 1'b0;
				end else begin
					vld_q[s] <= vld_in;
				end
			end

			always_ff @(posedge clk_in) begin
				win_q[s] <= win_in;
				acc_q[s] <= acc_in + prod;
			end
		end
	endgenerate

	assign sum_valid = vld_q[LAST];
	assign sum_win   = win_q[LAST];
	assign sum       = acc_q[LAST];

endmodule

`default_nettype wire

/* hw/operand_skew.sv */
`default_nettype none

module operand_skew (
	input  wire                 clk_in,
	input  wire                 arst_n,
	input  wire                 issue,
	input  conv_pkg::win_idx_t  issue_win,
	input  conv_pkg::pixel_t    image [conv_pkg::IMG_DIM * conv_pkg::IMG_DIM],
	tap_if.src                  taps
);

	logic valid_q;
	conv_pkg::win_idx_t win_q;
	conv_pkg::pixel_t sel [conv_pkg::N_TAPS];

	// Window register, stage 0 sees it one cycle after issue
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
			win_q   <= '0;
		end else begin
			valid_q <= issue;
			win_q   <= issue_win;
		end
	end

	// ----------------------------------------------------------------------
	// Window selector
	// ----------------------------------------------------------------------

	// Tap s reads image[out_row + s/3][out_col + s%3]
	always_comb begin
		int row;
		int col;
		row = int'(win_q) / conv_pkg::OUT_DIM;
		col = int'(win_q) % conv_pkg::OUT_DIM;
		for (int s = 0; s < conv_pkg::N_TAPS; s++) begin
			sel[s] = image[(row + s / conv_pkg::K_DIM) * conv_pkg::IMG_DIM
				+ col + s % conv_pkg::K_DIM];
		end
	end

	// ----------------------------------------------------------------------
	// Skew lines
	// ----------------------------------------------------------------------

	genvar s;
	generate
		for (s = 0; s < conv_pkg::N_TAPS; s++) begin : g_tap
			if (s == 0) begin : g_direct
				assign taps.pix[0] = sel[0];
			end else begin : g_delay
				// s-deep shift line so the pixel meets stage s
				conv_pkg::pixel_t line_q [s];

				always_ff @(posedge clk_in) begin
					line_q[0] <= sel[s];
					for (int i = 1; i < s; i++) begin
						line_q[i] <= line_q[i-1];
					end
				end

				assign taps.pix[s] = line_q[s-1];
			end
		end
	endgenerate

	assign taps.valid = valid_q;
	assign taps.win   = win_q;

endmodule

`default_nettype wire

/* hw/result_collector.sv */
`default_nettype none

module result_collector (
	input  wire                 clk_in,
	input  wire                 arst_n,
	input  wire                 sum_valid,
	input  conv_pkg::win_idx_t  sum_win,
	input  conv_pkg::acc_t      sum,
	output conv_pkg::acc_t      result [conv_pkg::N_WIN],
	output logic                done
);

	localparam conv_pkg::win_idx_t LAST_WIN = conv_pkg::win_idx_t'(conv_pkg::N_WIN - 1);

	logic last_sum;

	// Final window of a run closes it
	assign last_sum = sum_valid && (sum_win == LAST_WIN);

	// Slot picked by the window tag, held until overwritten
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			for (int w = 0; w < conv_pkg::N_WIN; w++) begin
				result[w] <= '0;
			end
		end else if (sum_valid) begin
			result[sum_win] <= sum;
		end
	end

	// Done pulses as the last slot is written
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
		end else begin
			done <= last_sum;
		end
	end

endmodule

`default_nettype wire

/* hw/tap_if.sv */
`default_nettype none

interface tap_if;

	// Element s already delayed s cycles
	conv_pkg::pixel_t pix [conv_pkg::N_TAPS];

	// Window entering stage 0 this cycle
	logic valid;
	conv_pkg::win_idx_t win;

	modport src (
		output pix,
		output valid,
		output win
	);

	modport snk (
		input pix,
		input valid,
		input win
	);

endinterface

`default_nettype wire

/* hw/window_sequencer.sv */
`default_nettype none

module window_sequencer (
	input  wire                 clk_in,
	input  wire                 arst_n,
	input  wire                 start,
	output logic                issue,
	output conv_pkg::win_idx_t  issue_win
);

	localparam conv_pkg::win_idx_t LAST_WIN = conv_pkg::win_idx_t'(conv_pkg::N_WIN - 1);

	logic busy;
	conv_pkg::win_idx_t win_cnt;

	// Plain up counter, one window per cycle while busy
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			busy    <= 1'b0;
			win_cnt <= '0;
		end else if (!busy) begin
			// Start only counts when idle
			if (start) begin
				busy    <= 1'b1;
				win_cnt <= '0;
			end
		end else begin
			if (win_cnt == LAST_WIN) begin
				busy <= 1'b0;
			end
			win_cnt <= win_cnt + 1'b1;
		end
	end

	assign issue     = busy;
	assign issue_win = win_cnt;

endmodule

`default_nettype wire

/* project.f */
hw/conv_pkg.sv
hw/tap_if.sv
hw/window_sequencer.sv
hw/operand_skew.sv
hw/mac_chain.sv
hw/result_collector.sv
hw/conv2d_systolic_top.sv
tests/tb_conv2d.sv

/* tests/tb_conv2d.sv */
`default_nettype none

module tb_conv2d;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_PIX      = conv_pkg::IMG_DIM * conv_pkg::IMG_DIM;
	localparam int N_ROWS     = 10;
	localparam int N_FIXED    = 3;
	localparam int RST_CYCLES = 8;
	localparam int WDOG_CYCLES = N_ROWS * (conv_pkg::RUN_LATENCY + 4) + 40;
	localparam realtime DRIVE_DELAY = 0.5;

	logic clk_in = 1'b0;
	logic arst_n;
	logic start;
	conv_pkg::pixel_t image [N_PIX];
	conv_pkg::pixel_t filter [conv_pkg::N_TAPS];
	conv_pkg::acc_t result [conv_pkg::N_WIN];
	logic done;

	// Stimulus and expected values with one run per row
	conv_pkg::pixel_t tbl_image [N_ROWS][N_PIX];
	conv_pkg::pixel_t tbl_filter [N_ROWS][conv_pkg::N_TAPS];
	conv_pkg::acc_t tbl_expect [N_ROWS][conv_pkg::N_WIN];
	// Edge that samples a stray second start or 0 for none
	int tbl_restart [N_ROWS];

	logic [31:0] lfsr_state;

	always #2 clk_in = ~clk_in;

	conv2d_systolic_top DUT (
		.clk_in (clk_in),
		.arst_n (arst_n),
		.start  (start),
		.image  (image),
		.filter (filter),
		.result (result),
		.done   (done)
	);

	// ----------------------------------------------------------------------
	// Random source and reference model
	// ----------------------------------------------------------------------

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_byte(output conv_pkg::pixel_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	// Sum of image[r+k][c+l] * filter[k][l] kept to 8 bits
	function automatic conv_pkg::acc_t conv_ref(input int r, input int w);
		int row;
		int col;
		int total;
		row = w / conv_pkg::OUT_DIM;
		col = w % conv_pkg::OUT_DIM;
		total = 0;
		for (int k = 0; k < conv_pkg::K_DIM; k++) begin
			for (int l = 0; l < conv_pkg::K_DIM; l++) begin
				total += int'(tbl_image[r][(row + k) * conv_pkg::IMG_DIM + col + l])
					* int'(tbl_filter[r][k * conv_pkg::K_DIM + l]);
			end
		end
		return conv_pkg::acc_t'(total % 256);
	endfunction

	task automatic build_table();
		int ctr;
		lfsr_state = 32'h6da794e6;
		ctr = conv_pkg::K_DIM / 2;
		// Corner rows in order all bytes at 255, zero filter and center tap only
		for (int i = 0; i < N_PIX; i++) begin
			tbl_image[0][i] = 8'hff;
			tbl_image[1][i] = conv_pkg::pixel_t'(i * 29 + 7);
			tbl_image[2][i] = conv_pkg::pixel_t'(i * 53 + 11);
		end
		for (int s = 0; s < conv_pkg::N_TAPS; s++) begin
			tbl_filter[0][s] = 8'hff;
			tbl_filter[1][s] = 8'h00;
			tbl_filter[2][s] = (s == ctr * conv_pkg::K_DIM + ctr) ? 8'h01 : 8'h00;
		end
		for (int w = 0; w < conv_pkg::N_WIN; w++) begin
			// 9 * 65025 mod 256
			tbl_expect[0][w] = 8'h09;
			// Zero filter overwrites the nines of the run before
			tbl_expect[1][w] = 8'h00;
			tbl_expect[2][w] = tbl_image[2][(w / conv_pkg::OUT_DIM + ctr) * conv_pkg::IMG_DIM
				+ w % conv_pkg::OUT_DIM + ctr];
		end
		for (int r = N_FIXED; r < N_ROWS; r++) begin
			for (int i = 0; i < N_PIX; i++) begin
				draw_byte(tbl_image[r][i]);
			end
			for (int s = 0; s < conv_pkg::N_TAPS; s++) begin
				draw_byte(tbl_filter[r][s]);
			end
			for (int w = 0; w < conv_pkg::N_WIN; w++) begin
				tbl_expect[r][w] = conv_ref(r, w);
			end
		end
		for (int r = 0; r < N_ROWS; r++) begin
			tbl_restart[r] = (r >= N_FIXED && r < N_FIXED + 3) ? r - N_FIXED + 1 : 0;
		end
	endtask

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	task automatic abort_on_error();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_result(input int slot, input conv_pkg::acc_t exp,
			input conv_pkg::acc_t got);
		if (got !== exp) begin
			$display("Mismatch result[%0d]: expected %h, got %h", slot, exp, got);
			abort_on_error();
		end
	endtask

	task automatic check_done(input string where, input logic exp, input logic got);
		if (got !== exp) begin
			$display("Mismatch done (%s): expected %h, got %h", where, exp, got);
			abort_on_error();
		end
	endtask

	// ----------------------------------------------------------------------
	// Runs one table row between two points just after a rising edge
	// ----------------------------------------------------------------------

	task automatic apply_row(input int r);
		int edges;
		logic seen_done;
		for (int i = 0; i < N_PIX; i++) begin
			image[i] = tbl_image[r][i];
		end
		for (int s = 0; s < conv_pkg::N_TAPS; s++) begin
			filter[s] = tbl_filter[r][s];
		end
		start = 1'b1;
		@(posedge clk_in);
		#DRIVE_DELAY;
		edges = 0;
		seen_done = 1'b0;
		// Done must appear exactly RUN_LATENCY edges after the start edge
		while (!seen_done) begin
			start = (tbl_restart[r] == edges + 1);
			@(negedge clk_in);
			check_done($sformatf("row %0d, edge %0d", r, edges),
				edges == conv_pkg::RUN_LATENCY, done);
			seen_done = done;
			@(posedge clk_in);
			#DRIVE_DELAY;
			edges++;
		end
		start = 1'b0;
		@(negedge clk_in);
		check_done($sformatf("row %0d, after pulse", r), 1'b0, done);
		for (int w = 0; w < conv_pkg::N_WIN; w++) begin
			check_result(w, tbl_expect[r][w], result[w]);
		end
		@(posedge clk_in);
		#DRIVE_DELAY;
	endtask

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		for (int i = 0; i < N_PIX; i++) begin
			image[i] = '0;
		end
		for (int s = 0; s < conv_pkg::N_TAPS; s++) begin
			filter[s] = '0;
		end
		build_table();
		repeat (RST_CYCLES) @(posedge clk_in);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		// Idle after reset
		repeat (3) begin
			@(negedge clk_in);
			check_done("idle after reset", 1'b0, done);
		end
		for (int w = 0; w < conv_pkg::N_WIN; w++) begin
			check_result(w, 8'h00, result[w]);
		end
		@(posedge clk_in);
		#DRIVE_DELAY;
		for (int r = 0; r < N_ROWS; r++) begin
			apply_row(r);
		end
		$display("Test completed successfully");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WDOG_CYCLES) @(posedge clk_in);
		$display("Watchdog expired before all table rows were run");
		abort_on_error();
	end

endmodule

`default_nettype wire
